/* src/fma_pkg.sv */
// FMA shared types and constants
package fma_pkg;

  // ------------------------------
  // Binary32 format constants
  // ------------------------------
  localparam int EXP_BITS       = 8;                  // Exponent field
  localparam int MAN_BITS       = 23;                 // Stored fraction
  localparam int PREC_BITS      = MAN_BITS + 1;       // Fraction plus implicit bit
  localparam int BIAS           = 127;
  localparam int SUM_BITS       = 3 * PREC_BITS + 4;  // Internal adder width
  localparam int LOWER_SUM_BITS = 2 * PREC_BITS + 3;  // Span searched by the LZC
  localparam int EXP_INT_BITS   = EXP_BITS + 2;       // Sign plus overflow headroom
  localparam int SHAMT_BITS     = $clog2(SUM_BITS + 1);
  localparam int LZC_BITS       = $clog2(LOWER_SUM_BITS);

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [EXP_BITS+MAN_BITS:0]     fp_word_t;  // Sign, exponent, fraction
  typedef logic signed [EXP_INT_BITS-1:0] exp_int_t;  // Biased internal exponent
  typedef logic [SUM_BITS-1:0]            sum_t;
  typedef logic [SHAMT_BITS-1:0]          shamt_t;
  typedef logic [LZC_BITS-1:0]            lzc_t;

  localparam fp_word_t QNAN = 32'h7FC0_0000;  // Canonical quiet NaN

  // FMADD and FNMSUB become FMSUB and FNMADD with op_mod set
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } op_e;

  // RISC-V rm field encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  typedef struct packed {
    logic nv;  // Invalid operation
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // ------------------------------
  // Datapath bundles
  // ------------------------------
  typedef struct packed {
    fp_word_t    operand_a;
    fp_word_t    operand_b;
    fp_word_t    operand_c;
    op_e         op;
    logic        op_mod;  // Flips the sign of the addend
    round_mode_e rnd_mode;
  } fma_req_t;

  // State between the adder and normalization
  typedef struct packed {
    logic        effective_subtraction;
    logic        final_sign;
    logic        sticky_before_add;
    exp_int_t    exponent_product;
    exp_int_t    exponent_difference;
    exp_int_t    tentative_exponent;
    shamt_t      addend_shamt;
    sum_t        sum;
    round_mode_e rnd_mode;
    logic        result_is_special;
    fp_word_t    special_result;
    status_t     special_status;
  } fma_mid_t;

  typedef struct packed {
    fp_word_t result;
    status_t  status;
  } fma_resp_t;

endpackage

/* src/fma_operand_prep.sv */
// FMA operand preparation and adder
module fma_operand_prep (
  input  fma_pkg::fma_req_t req_i,
  output fma_pkg::fma_mid_t mid_o
);
  import fma_pkg::*;

  localparam int       SIGN     = EXP_BITS + MAN_BITS;  // Sign bit position
  localparam fp_word_t ONE      = 32'h3F80_0000;        // Multiplicand for ADD
  localparam fp_word_t NEG_ZERO = 32'h8000_0000;        // Addend for MUL

  // ------------------------------
  // Operation table
  // ------------------------------
  fp_word_t [2:0] ops;  // a, b, c after adjustment

  always_comb begin : op_select
    ops[0] = req_i.operand_a;
    ops[1] = req_i.operand_b;
    ops[2] = req_i.operand_c;
    ops[2][SIGN] = ops[2][SIGN] ^ req_i.op_mod;  // Subtract variants
    unique case (req_i.op)
      FNMSUB:  ops[0][SIGN] = ~ops[0][SIGN];  // Negated product
      ADD:     ops[0] = ONE;
      MUL:     ops[2] = NEG_ZERO;  // -0 keeps zero products signed correctly
      default: ;                   // FMADD uses operands as given
    endcase
  end

  // ------------------------------
  // Classification
  // ------------------------------
  logic [2:0]                sgn, is_zero, is_normal, is_inf, is_nan, is_snan;
  logic [2:0][PREC_BITS-1:0] man;      // Mantissas with implicit bit
  exp_int_t                  exp_eff [3];

  for (genvar i = 0; i < 3; i++) begin : gen_class
    logic exp_zero, exp_ones, man_zero;

    assign exp_zero     = ~|ops[i][MAN_BITS+:EXP_BITS];
    assign exp_ones     = &ops[i][MAN_BITS+:EXP_BITS];
    assign man_zero     = ~|ops[i][MAN_BITS-1:0];
    assign sgn[i]       = ops[i][SIGN];
    assign is_zero[i]   = exp_zero & man_zero;
    assign is_normal[i] = ~exp_zero & ~exp_ones;  // Subnormal is the remaining zero exponent
    assign is_inf[i]    = exp_ones & man_zero;
    assign is_nan[i]    = exp_ones & ~man_zero;
    assign is_snan[i]   = is_nan[i] & ~ops[i][MAN_BITS-1];  // Quiet bit clear
    assign man[i]       = {is_normal[i], ops[i][MAN_BITS-1:0]};
    // Subnormals and zeros sit at encoded exponent 1
    assign exp_eff[i]   = exp_int_t'({1'b0, ops[i][MAN_BITS+:EXP_BITS]}) + exp_int_t'(exp_zero);
  end

  logic prod_sign, eff_sub, prod_inf;

  assign prod_sign = sgn[0] ^ sgn[1];     // Tentative sign
  assign eff_sub   = prod_sign ^ sgn[2];  // Product and addend signs differ
  assign prod_inf  = is_inf[0] | is_inf[1];

  // ------------------------------
  // Special cases
  // ------------------------------
  logic     special;
  fp_word_t special_result;
  status_t  special_status;

  always_comb begin : special_case
    special        = 1'b0;
    special_result = QNAN;
    special_status = '0;
    if ((is_inf[0] & is_zero[1]) | (is_zero[0] & is_inf[1])) begin
      special           = 1'b1;  // inf * 0 is invalid even with a NaN addend
      special_status.nv = 1'b1;
    end else if (|is_nan) begin
      special           = 1'b1;
      special_status.nv = |is_snan;  // Quiet NaNs pass silently
    end else if (|is_inf) begin
      special = 1'b1;
      if (prod_inf & is_inf[2] & eff_sub) begin
        special_status.nv = 1'b1;  // inf - inf
      end else begin
        // Product infinity wins, else the addend's
        special_result = {prod_inf ? prod_sign : sgn[2], {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end
    end
  end

  // ------------------------------
  // Exponent path
  // ------------------------------
  exp_int_t exp_product, exp_diff, exp_tentative;
  shamt_t   addend_shamt;

  // Zero product gets the minimum exponent
  assign exp_product   = (is_zero[0] | is_zero[1]) ? exp_int_t'(2 - BIAS)
                                                   : exp_int_t'(exp_eff[0] + exp_eff[1] - BIAS);
  assign exp_diff      = exp_eff[2] - exp_product;
  assign exp_tentative = (exp_diff > 0) ? exp_eff[2] : exp_product;

  always_comb begin : addend_shift_amount
    if (exp_diff <= -2 * PREC_BITS - 1) begin
      addend_shamt = shamt_t'(SUM_BITS);  // Addend lands in sticky only
    end else if (exp_diff <= PREC_BITS + 2) begin
      addend_shamt = shamt_t'(PREC_BITS + 3 - exp_diff);  // Overlapping bits
    end else begin
      addend_shamt = '0;  // Product lands in sticky only
    end
  end

  // ------------------------------
  // Mantissa path and adder
  // ------------------------------
  logic [2*PREC_BITS-1:0]        product;
  sum_t                          product_shifted, addend_after_shift, addend_shifted;
  logic [SUM_BITS+PREC_BITS-1:0] addend_wide;     // Extra p bits collect sticky
  logic                          sticky_before_add, inject_carry;
  logic [SUM_BITS:0]             sum_raw, sum_abs;

  assign product         = man[0] * man[1];
  assign product_shifted = sum_t'(product) << 2;  // Room for round and sticky

  assign addend_wide        = {man[2], {SUM_BITS{1'b0}}} >> addend_shamt;
  assign addend_after_shift = addend_wide[SUM_BITS+PREC_BITS-1:PREC_BITS];
  assign sticky_before_add  = |addend_wide[PREC_BITS-1:0];

  // Ones complement plus carry in, unless sticky bits absorb it
  assign addend_shifted = eff_sub ? ~addend_after_shift : addend_after_shift;
  assign inject_carry   = eff_sub & ~sticky_before_add;
  assign sum_raw        = product_shifted + addend_shifted + inject_carry;
  // No carry out of a subtraction means the result went negative
  assign sum_abs        = (eff_sub & ~sum_raw[SUM_BITS]) ? -sum_raw : sum_raw;

  assign mid_o = '{
    effective_subtraction: eff_sub,
    final_sign:            eff_sub ? (sum_raw[SUM_BITS] == prod_sign) : prod_sign,
    sticky_before_add:     sticky_before_add,
    exponent_product:      exp_product,
    exponent_difference:   exp_diff,
    tentative_exponent:    exp_tentative,
    addend_shamt:          addend_shamt,
    sum:                   sum_abs[SUM_BITS-1:0],
    rnd_mode:              req_i.rnd_mode,
    result_is_special:     special,
    special_result:        special_result,
    special_status:        special_status
  };

endmodule

/* src/fma_pipe_stage.sv */
// FMA register slice
module fma_pipe_stage (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  fma_pkg::fma_mid_t mid_i,
  input  logic              valid_i,
  output logic              ready_o,
  output fma_pkg::fma_mid_t mid_o,
  output logic              valid_o,
  input  logic              ready_i
);

  logic valid_q;

  // Empty or draining this cycle
  assign ready_o = ~valid_q | ready_i;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Clears when taken with nothing behind
    end
  end

  // Payload loads on an input transfer only
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      mid_o <= mid_i;
    end
  end

endmodule

/* src/fma_norm_round.sv */
// FMA normalization and rounding
module fma_norm_round (
  input  fma_pkg::fma_mid_t  mid_i,
  output fma_pkg::fma_resp_t resp_o
);
  import fma_pkg::*;

  // ------------------------------
  // Leading zero count
  // ------------------------------
  logic [LOWER_SUM_BITS-1:0] sum_lower;
  lzc_t                      leading_zero_count;
  logic                      lzc_zeroes;  // Nothing set in the lower sum

  assign sum_lower = mid_i.sum[LOWER_SUM_BITS-1:0];

  always_comb begin : lzc
    leading_zero_count = '0;
    lzc_zeroes         = 1'b1;
    for (int i = 0; i < LOWER_SUM_BITS; i++) begin
      if (sum_lower[i]) begin
        leading_zero_count = lzc_t'(LOWER_SUM_BITS - 1 - i);  // Highest one wins
        lzc_zeroes         = 1'b0;
      end
    end
  end

  // ------------------------------
  // Normalization
  // ------------------------------
  exp_int_t                  lzc_sgn, normalized_exponent, final_exponent;
  shamt_t                    norm_shamt;
  logic [SUM_BITS:0]         sum_shifted;      // Top bit catches a carry
  logic [PREC_BITS:0]        final_mantissa;   // Mantissa plus round bit
  logic [LOWER_SUM_BITS-1:0] sum_sticky_bits;
  logic                      sticky_after_norm;

  assign lzc_sgn = exp_int_t'(leading_zero_count);

  always_comb begin : norm_shift_amount
    // Product anchored or close cancellation
    if ((mid_i.exponent_difference <= 0) ||
        (mid_i.effective_subtraction && (mid_i.exponent_difference <= 2))) begin
      if ((mid_i.exponent_product - lzc_sgn + 1 >= 0) && !lzc_zeroes) begin
        norm_shamt          = shamt_t'(PREC_BITS + 2 + leading_zero_count);
        normalized_exponent = exp_int_t'(mid_i.exponent_product - lzc_sgn + 1);
      end else begin
        // Subnormal result so the shift stops at the minimum exponent
        norm_shamt          = shamt_t'(PREC_BITS + 2 + mid_i.exponent_product);
        normalized_exponent = '0;
      end
    end else begin
      norm_shamt          = mid_i.addend_shamt;  // Undo the addend alignment
      normalized_exponent = mid_i.tentative_exponent;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // Leading one may still sit one place off
  always_comb begin : small_norm
    {final_mantissa, sum_sticky_bits} = sum_shifted[SUM_BITS-1:0];
    final_exponent                    = normalized_exponent;
    if (sum_shifted[SUM_BITS]) begin
      {final_mantissa, sum_sticky_bits} = sum_shifted[SUM_BITS:1];
      final_exponent                    = exp_int_t'(normalized_exponent + 1);
    end else if (!sum_shifted[SUM_BITS-1]) begin
      if (normalized_exponent > 1) begin
        {final_mantissa, sum_sticky_bits} = {sum_shifted[SUM_BITS-2:0], 1'b0};
        final_exponent                    = exp_int_t'(normalized_exponent - 1);
      end else begin
        final_exponent = '0;  // Stays subnormal
      end
    end
  end

  assign sticky_after_norm = (|sum_sticky_bits) | mid_i.sticky_before_add;

  // ------------------------------
  // Rounding
  // ------------------------------
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs, rounded_abs;
  logic [1:0]                   round_sticky_bits;
  logic                         of_before_round, of_after_round, uf_after_round;
  logic                         round_up, exact_zero, rounded_sign, inexact;

  assign of_before_round = final_exponent >= (2 ** EXP_BITS - 1);

  // Overflow rounds from the largest finite value
  assign pre_round_abs = of_before_round
                       ? {{(EXP_BITS-1){1'b1}}, 1'b0, {MAN_BITS{1'b1}}}
                       : {final_exponent[EXP_BITS-1:0], final_mantissa[MAN_BITS:1]};
  assign round_sticky_bits = {final_mantissa[0] | of_before_round,
                              sticky_after_norm | of_before_round};

  always_comb begin : round_decision
    unique case (mid_i.rnd_mode)
      RNE:     round_up = round_sticky_bits[1] & (round_sticky_bits[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky_bits) & mid_i.final_sign;
      RUP:     round_up = (|round_sticky_bits) & ~mid_i.final_sign;
      RMM:     round_up = round_sticky_bits[1];  // Ties away from zero
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + {{(EXP_BITS+MAN_BITS-1){1'b0}}, round_up};
  assign exact_zero  = (pre_round_abs == '0) && (round_sticky_bits == '0);
  // Cancelled sums are -0 only when rounding down
  assign rounded_sign = (exact_zero && mid_i.effective_subtraction)
                      ? (mid_i.rnd_mode == RDN) : mid_i.final_sign;

  assign of_after_round = &rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];  // Carried into inf
  assign uf_after_round = ~|rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];
  assign inexact        = (|round_sticky_bits) | of_before_round | of_after_round;

  // ------------------------------
  // Result selection
  // ------------------------------
  fma_resp_t regular_resp, special_resp;

  assign regular_resp = '{
    result: {rounded_sign, rounded_abs},
    status: '{
      nv: 1'b0,
      of: of_before_round | of_after_round,
      uf: uf_after_round & inexact,  // Tiny and inexact
      nx: inexact
    }
  };
  assign special_resp = '{result: mid_i.special_result, status: mid_i.special_status};

  assign resp_o = mid_i.result_is_special ? special_resp : regular_resp;

endmodule

/* src/fma_top.sv */
// Binary32 FMA unit
module fma_top #(
  parameter int unsigned NUM_PIPE_REGS = 2  // Slices between adder and normalizer
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  fma_pkg::fma_req_t  req_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  output fma_pkg::fma_resp_t resp_o,
  output logic               out_valid_o,
  input  logic               out_ready_i
);
  import fma_pkg::*;

  // Entry k is the input of stage k
  fma_mid_t [NUM_PIPE_REGS:0] mid;
  logic     [NUM_PIPE_REGS:0] valid;
  logic     [NUM_PIPE_REGS:0] ready;  // Ripples back combinationally

  assign valid[0]             = in_valid_i;
  assign in_ready_o           = ready[0];
  assign ready[NUM_PIPE_REGS] = out_ready_i;
  assign out_valid_o          = valid[NUM_PIPE_REGS];

  fma_operand_prep i_prep (
    .req_i (req_i),
    .mid_o (mid[0])
  );

  // ------------------------------
  // Inside pipeline
  // ------------------------------
  for (genvar k = 0; k < NUM_PIPE_REGS; k++) begin : gen_stage
    fma_pipe_stage i_stage (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .mid_i   (mid[k]),
      .valid_i (valid[k]),
      .ready_o (ready[k]),
      .mid_o   (mid[k+1]),
      .valid_o (valid[k+1]),
      .ready_i (ready[k+1])
    );
  end

  fma_norm_round i_norm (
    .mid_i  (mid[NUM_PIPE_REGS]),
    .resp_o (resp_o)
  );

endmodule

/* bench/fma_assert.sv */
// FMA handshake assertions
module fma_assert (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               in_ready_i,
  input fma_pkg::fma_resp_t resp_i,
  input logic               out_valid_i,
  input logic               out_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Assertion failures so far

  // Every reset edge empties the pipeline
  a_valid_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
      $error("out_valid_o high after a reset edge");
      fail_count++;
    end

  // Stalled output holds valid and data
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(resp_i))
    else begin
      $error("Stalled response changed or was dropped");
      fail_count++;
    end

  a_ready_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> in_ready_i)
    else begin
      $error("in_ready_o low on the first cycle out of reset");
      fail_count++;
    end

endmodule

bind fma_top fma_assert u_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_ready_i  (in_ready_o),
  .resp_i      (resp_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i)
);

/* bench/tb_fma_top.sv */
// FMA unit testbench
module tb_fma_top;
  timeunit 1ns;
  timeprecision 100ps;
  import fma_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  // Operand encodings
  localparam fp_word_t P_ZERO    = 32'h0000_0000;
  localparam fp_word_t P_ONE     = 32'h3F80_0000;
  localparam fp_word_t N_ONE     = 32'hBF80_0000;
  localparam fp_word_t P_ONE5    = 32'h3FC0_0000;  // 1.5
  localparam fp_word_t P_TWO     = 32'h4000_0000;
  localparam fp_word_t P_TWO5    = 32'h4020_0000;  // 2.5
  localparam fp_word_t P_THREE   = 32'h4040_0000;
  localparam fp_word_t P_INF     = 32'h7F80_0000;
  localparam fp_word_t N_INF     = 32'hFF80_0000;
  localparam fp_word_t QNAN_IN   = 32'h7FC0_1234;  // Quiet with payload
  localparam fp_word_t SNAN_IN   = 32'h7F80_0001;  // Quiet bit clear
  localparam fp_word_t TINY      = 32'h3380_0000;  // 2^-24 is half an ulp of 1.0
  localparam fp_word_t MAX_FIN   = 32'h7F7F_FFFF;
  localparam fp_word_t CANON_NAN = 32'h7FC0_0000;

  // Flag patterns in nv, of, uf, nx order
  localparam status_t NONE  = 4'b0000;
  localparam status_t NV    = 4'b1000;
  localparam status_t NX    = 4'b0001;
  localparam status_t OF_NX = 4'b0101;

  logic      clk_i, rst_n_i;
  fma_req_t  req_i;
  logic      in_valid_i, in_ready_o;
  fma_resp_t resp_o;
  logic      out_valid_o, out_ready_i;

  fma_req_t    req_table[$];
  fma_resp_t   exp_table[$];
  fma_resp_t   expected_q[$];  // Accepted but not yet returned
  int          result_errors, status_errors, protocol_errors, assert_errors, resp_count;
  logic        done;
  logic [15:0] lfsr;

  fma_top #(.NUM_PIPE_REGS(2)) dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .resp_o      (resp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic add_entry(input fp_word_t a, input fp_word_t b, input fp_word_t c,
                           input op_e op, input logic op_mod, input round_mode_e rm,
                           input fp_word_t result, input status_t status);
    req_table.push_back('{operand_a: a, operand_b: b, operand_c: c,
                          op: op, op_mod: op_mod, rnd_mode: rm});
    exp_table.push_back('{result: result, status: status});
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic build_table();
    add_entry(P_TWO, P_THREE, P_ONE, FMADD, 1'b0, RNE, 32'h40E0_0000, NONE);   // 7
    add_entry(P_TWO, P_THREE, P_ONE, FMADD, 1'b1, RNE, 32'h40A0_0000, NONE);   // 5
    add_entry(P_TWO, P_THREE, P_ONE, FNMSUB, 1'b0, RNE, 32'hC0A0_0000, NONE);  // -5
    add_entry(P_TWO, P_THREE, P_ONE, FNMSUB, 1'b1, RNE, 32'hC0E0_0000, NONE);  // -7
    add_entry(P_ONE, P_ONE, P_ONE, FMADD, 1'b1, RNE, 32'h0000_0000, NONE);     // Cancels to +0
    add_entry(P_ONE, P_ONE, P_ONE, FMADD, 1'b1, RDN, 32'h8000_0000, NONE);     // -0 rounding down
    add_entry(P_THREE, P_ONE5, P_TWO5, ADD, 1'b0, RNE, 32'h4080_0000, NONE);   // a ignored
    add_entry(P_THREE, P_ONE5, P_TWO5, ADD, 1'b1, RNE, 32'hBF80_0000, NONE);
    add_entry(P_TWO, P_THREE, P_ONE, MUL, 1'b0, RNE, 32'h40C0_0000, NONE);     // c ignored
    add_entry(P_ZERO, N_ONE, P_ONE, MUL, 1'b0, RNE, 32'h8000_0000, NONE);
    add_entry(QNAN_IN, P_ONE, P_ONE, FMADD, 1'b0, RNE, CANON_NAN, NONE);
    add_entry(P_ONE, SNAN_IN, P_ONE, FMADD, 1'b0, RNE, CANON_NAN, NV);
    add_entry(P_INF, P_ZERO, P_ONE, FMADD, 1'b0, RNE, CANON_NAN, NV);
    add_entry(P_INF, P_ONE, N_INF, FMADD, 1'b0, RNE, CANON_NAN, NV);           // inf - inf
    add_entry(P_INF, P_TWO, P_ONE, FMADD, 1'b0, RNE, P_INF, NONE);
    add_entry(P_ONE, P_ONE, TINY, FMADD, 1'b0, RNE, 32'h3F80_0000, NX);        // Tie to even
    add_entry(P_ONE, P_ONE, TINY, FMADD, 1'b0, RTZ, 32'h3F80_0000, NX);
    add_entry(P_ONE, P_ONE, TINY, FMADD, 1'b0, RUP, 32'h3F80_0001, NX);
    add_entry(MAX_FIN, P_TWO, P_ZERO, FMADD, 1'b0, RNE, P_INF, OF_NX);
    add_entry(MAX_FIN, P_TWO, P_ZERO, FMADD, 1'b0, RTZ, MAX_FIN, OF_NX);       // Saturates
  endtask

  task automatic check_result(input fp_word_t got, input fp_word_t want, input int idx);
    if (got !== want) begin
      $display("FAILED at %0d ns: entry %0d result %h, expected %h", $time, idx, got, want);
      result_errors++;
    end
  endtask

  task automatic check_status(input status_t got, input status_t want, input int idx);
    if (got !== want) begin
      $display("FAILED at %0d ns: entry %0d flags %b, expected %b", $time, idx, got, want);
      status_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0d ns: %s did not happen within %0d cycles", $time, what, TIMEOUT);
    $display("Errors found");
    $finish;
  endtask

  // ------------------------------
  // Stimulus and response
  // ------------------------------
  task automatic drive_requests();
    int   wait_cycles;
    logic accepted;
    for (int i = 0; i < req_table.size(); i++) begin
      req_i       = req_table[i];
      in_valid_i  = 1'b1;
      wait_cycles = 0;
      accepted    = 1'b0;
      while (!accepted) begin
        @(negedge clk_i);  // Ready is settled mid-cycle
        if (in_ready_o) begin
          accepted = 1'b1;
          expected_q.push_back(exp_table[i]);
        end
        @(posedge clk_i);
        #2;
        wait_cycles++;
        if (!accepted && wait_cycles > TIMEOUT) report_timeout("in_ready_o");
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic collect_responses();
    fma_resp_t want;
    int        idle;
    idle = 0;
    while (resp_count < req_table.size()) begin
      @(negedge clk_i);
      if (out_valid_o && out_ready_i) begin
        if (expected_q.size() == 0) begin
          $display("Response %0d arrived before its request was accepted", resp_count);
          protocol_errors++;
        end else begin
          want = expected_q.pop_front();  // In order of acceptance
          check_result(resp_o.result, want.result, resp_count);
          check_status(resp_o.status, want.status, resp_count);
        end
        resp_count++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) report_timeout("out_valid_o");
      end
    end
    // Nothing more may follow the last entry
    repeat (4) begin
      @(negedge clk_i);
      if (out_valid_o) begin
        $display("Extra response seen after all %0d entries", resp_count);
        protocol_errors++;
      end
    end
    done = 1'b1;
  endtask

  task automatic drive_out_ready();
    while (!done) begin
      lfsr        = lfsr_step(lfsr);
      out_ready_i = lfsr[0];  // Fresh bit each cycle
      @(posedge clk_i);
      #2;
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    req_i           = '0;
    in_valid_i      = 1'b0;
    out_ready_i     = 1'b0;
    result_errors   = 0;
    status_errors   = 0;
    protocol_errors = 0;
    resp_count      = 0;
    done            = 1'b0;
    lfsr            = 16'd42;
    build_table();
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    fork
      drive_requests();
      collect_responses();
      drive_out_ready();
    join
    if (expected_q.size() != 0) begin
      $display("%0d accepted requests never produced a response", expected_q.size());
      protocol_errors++;
    end
    assert_errors = dut.u_assert.fail_count;
    $display("Result errors: %0d, status errors: %0d, protocol errors: %0d, assertions: %0d",
             result_errors, status_errors, protocol_errors, assert_errors);
    if (result_errors + status_errors + protocol_errors + assert_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* src.f */
src/fma_pkg.sv
src/fma_operand_prep.sv
src/fma_pipe_stage.sv
src/fma_norm_round.sv
src/fma_top.sv
bench/fma_assert.sv
bench/tb_fma_top.sv

/* Makefile */
# Verilator flow for the FMA unit

BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint clean

all: $(BUILD)/Vtb_fma_top
	./$(BUILD)/Vtb_fma_top +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Errors found" $(LOG)
	grep -q "No errors" $(LOG)

$(BUILD)/Vtb_fma_top: src.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_fma_top -Mdir $(BUILD)

lint:
	verilator --lint-only -Wall -f src.f --top-module tb_fma_top --timing

clean:
	rm -rf $(BUILD) $(LOG)
